//--- list.f
+incdir+include
rtl/xbar_pkg.sv
rtl/addr_decoder.sv
rtl/rr_arb_mux.sv
rtl/initiator_port.sv
rtl/target_port.sv
rtl/xbar_node.sv
test/tb_xbar_node.sv

//--- include/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
  logic [IDX_W-1:0]  init;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] strb;
  logic [ID_W-1:0]   id;
  resp_e             exp_resp;
  logic [DATA_W-1:0] exp_rdata;
} vec_t;

localparam int NB_VEC = 17;

// init, we, addr, wdata, strb, id, expected resp, expected rdata
localparam vec_t VECTORS [NB_VEC] = '{
  '{2'd0, 1'b1, 32'h0000_0100, 32'hA5A5_0001, 4'hF, 4'd1,  OKAY,   32'h0000_0000},
  '{2'd0, 1'b0, 32'h0000_0100, 32'h0000_0000, 4'h0, 4'd2,  OKAY,   32'hA5A5_0001},
  '{2'd0, 1'b0, 32'h0000_3000, 32'h0000_0000, 4'h0, 4'd3,  DECERR, 32'h0000_0000},
  '{2'd0, 1'b1, 32'h0000_0200, 32'h1111_0004, 4'hF, 4'd4,  OKAY,   32'h0000_0000},
  '{2'd0, 1'b1, 32'h0000_0204, 32'h1111_0005, 4'hF, 4'd5,  OKAY,   32'h0000_0000},
  '{2'd0, 1'b0, 32'h0000_0200, 32'h0000_0000, 4'h0, 4'd6,  OKAY,   32'h1111_0004},
  '{2'd0, 1'b1, 32'h0000_0400, 32'h2222_0007, 4'hF, 4'd7,  OKAY,   32'h0000_0000},
  '{2'd0, 1'b1, 32'h0000_1400, 32'h2222_0008, 4'hF, 4'd8,  OKAY,   32'h0000_0000},
  '{2'd0, 1'b0, 32'h0000_0400, 32'h0000_0000, 4'h0, 4'd9,  OKAY,   32'h2222_0007},
  '{2'd0, 1'b0, 32'h0000_1400, 32'h0000_0000, 4'h0, 4'd10, OKAY,   32'h2222_0008},
  '{2'd1, 1'b1, 32'h0000_1100, 32'h5A5A_0001, 4'hF, 4'd1,  OKAY,   32'h0000_0000},
  '{2'd1, 1'b0, 32'h0000_1100, 32'h0000_0000, 4'h0, 4'd2,  OKAY,   32'h5A5A_0001},
  '{2'd1, 1'b1, 32'h8000_0000, 32'hDEAD_0003, 4'hF, 4'd3,  DECERR, 32'h0000_0000},
  '{2'd1, 1'b1, 32'h0000_0300, 32'h3333_0004, 4'hF, 4'd4,  OKAY,   32'h0000_0000},
  '{2'd1, 1'b1, 32'h0000_0304, 32'h3333_0005, 4'hF, 4'd5,  OKAY,   32'h0000_0000},
  '{2'd1, 1'b0, 32'h0000_0300, 32'h0000_0000, 4'h0, 4'd6,  OKAY,   32'h3333_0004},
  '{2'd1, 1'b0, 32'h0000_0304, 32'h0000_0000, 4'h0, 4'd7,  OKAY,   32'h3333_0005}
};

`endif

//--- test/tb_xbar_node.sv
`timescale 1ns/1ns

module tb_xbar_node
  import xbar_pkg::*;
;

  `include "tb_vectors.svh"

  localparam int NB_INIT = 2;
  localparam int NB_TARG = 2;
  localparam int OUTST_MAX = 2**OUTST_W - 1;
  localparam logic [ADDR_W-1:0] MAP_START [NB_TARG] = '{32'h0000_0000, 32'h0000_1000};
  localparam logic [ADDR_W-1:0] MAP_END   [NB_TARG] = '{32'h0000_0FFF, 32'h0000_1FFF};

  logic                           clk;
  logic                           rst_i = 1'b1;
  init_req_t                      init_req_i [NB_INIT-1:0];
  logic [NB_INIT-1:0]             init_req_valid_i;
  logic [NB_INIT-1:0]             init_req_ready_o;
  init_rsp_t                      init_rsp_o [NB_INIT-1:0];
  logic [NB_INIT-1:0]             init_rsp_valid_o;
  logic [NB_INIT-1:0]             init_rsp_ready_i;
  targ_req_t                      targ_req_o [NB_TARG-1:0];
  logic [NB_TARG-1:0]             targ_req_valid_o;
  logic [NB_TARG-1:0]             targ_req_ready_i;
  targ_rsp_t                      targ_rsp_i [NB_TARG-1:0];
  logic [NB_TARG-1:0]             targ_rsp_valid_i;
  logic [NB_TARG-1:0]             targ_rsp_ready_o;
  logic [NB_TARG-1:0][ADDR_W-1:0] start_addr_i;
  logic [NB_TARG-1:0][ADDR_W-1:0] end_addr_i;

  int n_checks;
  int n_errors;
  int done_cnt;
  // Per initiator view of accepted requests still waiting for a response
  int outst    [NB_INIT];
  int last_tgt [NB_INIT];
  int cur_row  [NB_INIT];
  logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];

  xbar_node #(
    .NB_INIT          ( NB_INIT          ),
    .NB_TARG          ( NB_TARG          )
  ) dut (
    .clk              ( clk              ),
    .rst_i            ( rst_i            ),
    .init_req_i       ( init_req_i       ),
    .init_req_valid_i ( init_req_valid_i ),
    .init_req_ready_o ( init_req_ready_o ),
    .init_rsp_o       ( init_rsp_o       ),
    .init_rsp_valid_o ( init_rsp_valid_o ),
    .init_rsp_ready_i ( init_rsp_ready_i ),
    .targ_req_o       ( targ_req_o       ),
    .targ_req_valid_o ( targ_req_valid_o ),
    .targ_req_ready_i ( targ_req_ready_i ),
    .targ_rsp_i       ( targ_rsp_i       ),
    .targ_rsp_valid_i ( targ_rsp_valid_i ),
    .targ_rsp_ready_o ( targ_rsp_ready_o ),
    .start_addr_i     ( start_addr_i     ),
    .end_addr_i       ( end_addr_i       )
  );

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_problem(input string msg);
    n_errors++;
    $display("%s", msg);
  endtask

  // Lowest matching range wins, NB_TARG means no target
  function automatic int decode_target(input logic [ADDR_W-1:0] addr);
    for (int t = 0; t < NB_TARG; t++)
    begin
      if ((addr >= MAP_START[t]) && (addr <= MAP_END[t]))
        return t;
    end
    return NB_TARG;
  endfunction

  // Request of initiator j is offered to target 0 when the ordering guard lets it through
  function automatic logic waiting_for_t0(input int j);
    return init_req_valid_i[j] && (decode_target(init_req_i[j].addr) == 0) &&
           (outst[j] < OUTST_MAX) && ((outst[j] == 0) || (last_tgt[j] == 0));
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    void'($urandom(69783));
    for (int i = 0; i < NB_INIT; i++)
      init_req_i[i] = '0;
    for (int t = 0; t < NB_TARG; t++)
    begin
      targ_rsp_i[t]   = '0;
      start_addr_i[t] = MAP_START[t];
      end_addr_i[t]   = MAP_END[t];
    end
    init_req_valid_i = '0;
    init_rsp_ready_i = '0;
    targ_req_ready_i = '0;
    targ_rsp_valid_i = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_i = 1'b0;
    wait (done_cnt == NB_VEC);
    repeat (20) @(posedge clk);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  initial
  begin
    repeat (NB_VEC * 200) @(posedge clk);
    $display("Timeout: only %0d of %0d rows completed within %0d cycles",
             done_cnt, NB_VEC, NB_VEC * 200);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
    $display("Some tests failed");
    $finish;
  end

  for (genvar i = 0; i < NB_INIT; i++)
  begin : g_ini
    int inflight [$];

    // Issues its rows back to back without waiting for responses
    initial
    begin
      wait (rst_i == 1'b0);
      @(posedge clk);
      #1;
      for (int r = 0; r < NB_VEC; r++)
      begin
        if (VECTORS[r].init == IDX_W'(i))
        begin
          cur_row[i] = r;
          init_req_i[i] = '{addr: VECTORS[r].addr, we: VECTORS[r].we,
                            wdata: VECTORS[r].wdata, strb: VECTORS[r].strb,
                            id: VECTORS[r].id};
          init_req_valid_i[i] = 1'b1;
          do
            @(negedge clk);
          while (!init_req_ready_o[i]);
          @(posedge clk);
          inflight.push_back(r);
          outst[i]++;
          last_tgt[i] = decode_target(VECTORS[r].addr);
          #1;
        end
      end
      init_req_valid_i[i] = 1'b0;
    end

    // Responses must come back in issue order
    initial
    begin
      logic fired;
      int   r;
      wait (rst_i == 1'b0);
      forever
      begin
        @(negedge clk);
        fired = init_rsp_valid_o[i] && init_rsp_ready_i[i];
        if (fired && (inflight.size() == 0))
          report_problem($sformatf("Initiator %0d got a response with nothing in flight", i));
        else if (fired)
        begin
          r = inflight[0];
          check_val("init_rsp_o.id", init_rsp_o[i].id, VECTORS[r].id);
          check_val("init_rsp_o.resp", init_rsp_o[i].resp, VECTORS[r].exp_resp);
          check_val("init_rsp_o.rdata", init_rsp_o[i].rdata, VECTORS[r].exp_rdata);
        end
        @(posedge clk);
        if (fired && (inflight.size() > 0))
        begin
          void'(inflight.pop_front());
          outst[i]--;
          done_cnt++;
        end
        #1;
        init_rsp_ready_i[i] = ($urandom % 4) != 0;
      end
    end
  end

  for (genvar t = 0; t < NB_TARG; t++)
  begin : g_tmodel
    targ_rsp_t rspq [$];

    // Target 0 is the slow one
    initial
    begin
      targ_req_t         held;
      targ_rsp_t         rsp;
      logic              stalled;
      logic              popped;
      logic [DATA_W-1:0] word;
      int                gap;
      int                src;
      int                exp_idx;
      int                r;
      stalled = 1'b0;
      gap     = 0;
      exp_idx = -1;
      wait (rst_i == 1'b0);
      forever
      begin
        @(negedge clk);
        if (stalled && !targ_req_valid_o[t])
          report_problem($sformatf("Target %0d request valid dropped before transfer", t));
        else if (stalled)
          check_val("targ_req_o", targ_req_o[t], held);
        stalled = targ_req_valid_o[t] && !targ_req_ready_i[t];
        held    = targ_req_o[t];
        if (targ_req_valid_o[t] && targ_req_ready_i[t])
        begin
          // Issuing initiator is the one whose own handshake fires toward this target
          src = -1;
          for (int k = 0; k < NB_INIT; k++)
          begin
            if (init_req_valid_i[k] && init_req_ready_o[k] &&
                (decode_target(init_req_i[k].addr) == t))
              src = k;
          end
          if (src < 0)
            report_problem($sformatf("Target %0d got a request that no initiator issued", t));
          else
          begin
            r = cur_row[src];
            check_val("targ_req_o.id", targ_req_o[t].id, {IDX_W'(src), VECTORS[r].id});
            check_val("targ_req_o.addr", targ_req_o[t].addr, VECTORS[r].addr);
            check_val("targ_req_o.we", targ_req_o[t].we, VECTORS[r].we);
            check_val("targ_req_o.wdata", targ_req_o[t].wdata, VECTORS[r].wdata);
            check_val("targ_req_o.strb", targ_req_o[t].strb, VECTORS[r].strb);
            if (t == 0)
            begin
              if (exp_idx >= 0)
                check_val("target 0 grant index", src, exp_idx);
              exp_idx = waiting_for_t0(1 - src) ? 1 - src : -1;
            end
          end
          word = mem.exists(targ_req_o[t].addr) ? mem[targ_req_o[t].addr] : '0;
          rsp  = '{rdata: word, resp: OKAY, id: targ_req_o[t].id};
          if (targ_req_o[t].we)
          begin
            for (int b = 0; b < STRB_W; b++)
            begin
              if (targ_req_o[t].strb[b])
                word[8*b +: 8] = targ_req_o[t].wdata[8*b +: 8];
            end
            mem[targ_req_o[t].addr] = word;
            rsp.rdata = '0;
          end
          rspq.push_back(rsp);
        end
        popped = targ_rsp_valid_i[t] && targ_rsp_ready_o[t];
        @(posedge clk);
        #1;
        if (popped)
        begin
          void'(rspq.pop_front());
          targ_rsp_valid_i[t] = 1'b0;
          gap = $urandom % ((t == 0) ? 6 : 2);
        end
        if (!targ_rsp_valid_i[t] && (rspq.size() > 0) && (gap == 0))
        begin
          targ_rsp_i[t]       = rspq[0];
          targ_rsp_valid_i[t] = 1'b1;
        end
        else if (!targ_rsp_valid_i[t] && (rspq.size() > 0))
          gap--;
        targ_req_ready_i[t] = ($urandom % ((t == 0) ? 2 : 4)) != 0;
      end
    end
  end

endmodule

//--- rtl/xbar_node.sv
`timescale 1ns/1ns

module xbar_node
  import xbar_pkg::*;
#(
  parameter int NB_INIT = 2,
  parameter int NB_TARG = 2
)
(
  input  logic                           clk,
  input  logic                           rst_i,
  input  init_req_t                      init_req_i [NB_INIT-1:0],
  input  logic [NB_INIT-1:0]             init_req_valid_i,
  output logic [NB_INIT-1:0]             init_req_ready_o,
  output init_rsp_t                      init_rsp_o [NB_INIT-1:0],
  output logic [NB_INIT-1:0]             init_rsp_valid_o,
  input  logic [NB_INIT-1:0]             init_rsp_ready_i,
  output targ_req_t                      targ_req_o [NB_TARG-1:0],
  output logic [NB_TARG-1:0]             targ_req_valid_o,
  input  logic [NB_TARG-1:0]             targ_req_ready_i,
  input  targ_rsp_t                      targ_rsp_i [NB_TARG-1:0],
  input  logic [NB_TARG-1:0]             targ_rsp_valid_i,
  output logic [NB_TARG-1:0]             targ_rsp_ready_o,
  input  logic [NB_TARG-1:0][ADDR_W-1:0] start_addr_i,
  input  logic [NB_TARG-1:0][ADDR_W-1:0] end_addr_i
);

  // Indexed [initiator][target]
  targ_req_t                       ip_req [NB_INIT-1:0];
  logic [NB_INIT-1:0][NB_TARG-1:0] ip_req_valid;
  logic [NB_INIT-1:0][NB_TARG-1:0] ip_req_ready;
  logic [NB_INIT-1:0][NB_TARG-1:0] ip_rsp_valid;
  logic [NB_INIT-1:0][NB_TARG-1:0] ip_rsp_ready;
  // Indexed [target][initiator]
  targ_rsp_t                       tp_rsp [NB_TARG-1:0];
  logic [NB_TARG-1:0][NB_INIT-1:0] tp_req_valid;
  logic [NB_TARG-1:0][NB_INIT-1:0] tp_req_ready;
  logic [NB_TARG-1:0][NB_INIT-1:0] tp_rsp_valid;
  logic [NB_TARG-1:0][NB_INIT-1:0] tp_rsp_ready;

  for (genvar i = 0; i < NB_INIT; i++)
  begin : g_init
    initiator_port #(
      .NB_TARG      ( NB_TARG             ),
      .PORT_IDX     ( i                   )
    ) u_init (
      .clk          ( clk                 ),
      .rst_i        ( rst_i               ),
      .req_i        ( init_req_i[i]       ),
      .req_valid_i  ( init_req_valid_i[i] ),
      .req_ready_o  ( init_req_ready_o[i] ),
      .rsp_o        ( init_rsp_o[i]       ),
      .rsp_valid_o  ( init_rsp_valid_o[i] ),
      .rsp_ready_i  ( init_rsp_ready_i[i] ),
      .start_addr_i ( start_addr_i        ),
      .end_addr_i   ( end_addr_i          ),
      .treq_o       ( ip_req[i]           ),
      .treq_valid_o ( ip_req_valid[i]     ),
      .treq_ready_i ( ip_req_ready[i]     ),
      .trsp_i       ( tp_rsp              ),
      .trsp_valid_i ( ip_rsp_valid[i]     ),
      .trsp_ready_o ( ip_rsp_ready[i]     )
    );

    for (genvar t = 0; t < NB_TARG; t++)
    begin : g_cross
      assign tp_req_valid[t][i] = ip_req_valid[i][t];
      assign ip_req_ready[i][t] = tp_req_ready[t][i];
      assign ip_rsp_valid[i][t] = tp_rsp_valid[t][i];
      assign tp_rsp_ready[t][i] = ip_rsp_ready[i][t];
    end
  end

  for (genvar t = 0; t < NB_TARG; t++)
  begin : g_targ
    target_port #(
      .NB_INIT      ( NB_INIT             )
    ) u_targ (
      .clk          ( clk                 ),
      .rst_i        ( rst_i               ),
      .ireq_i       ( ip_req              ),
      .ireq_valid_i ( tp_req_valid[t]     ),
      .ireq_ready_o ( tp_req_ready[t]     ),
      .req_o        ( targ_req_o[t]       ),
      .req_valid_o  ( targ_req_valid_o[t] ),
      .req_ready_i  ( targ_req_ready_i[t] ),
      .rsp_i        ( targ_rsp_i[t]       ),
      .rsp_valid_i  ( targ_rsp_valid_i[t] ),
      .rsp_ready_o  ( targ_rsp_ready_o[t] ),
      .irsp_o       ( tp_rsp[t]           ),
      .irsp_valid_o ( tp_rsp_valid[t]     ),
      .irsp_ready_i ( tp_rsp_ready[t]     )
    );
  end

endmodule

//--- rtl/target_port.sv
`timescale 1ns/1ns

module target_port
  import xbar_pkg::*;
#(
  parameter int NB_INIT = 2
)
(
  input  logic               clk,
  input  logic               rst_i,
  input  targ_req_t          ireq_i [NB_INIT-1:0],
  input  logic [NB_INIT-1:0] ireq_valid_i,
  output logic [NB_INIT-1:0] ireq_ready_o,
  output targ_req_t          req_o,
  output logic               req_valid_o,
  input  logic               req_ready_i,
  input  targ_rsp_t          rsp_i,
  input  logic               rsp_valid_i,
  output logic               rsp_ready_o,
  output targ_rsp_t          irsp_o,
  output logic [NB_INIT-1:0] irsp_valid_o,
  input  logic [NB_INIT-1:0] irsp_ready_i
);

  logic [IDX_W-1:0] dst;

  rr_arb_mux #(
    .payload_t   ( targ_req_t   ),
    .N           ( NB_INIT      )
  ) u_req_arb (
    .clk         ( clk          ),
    .rst_i       ( rst_i        ),
    .in_i        ( ireq_i       ),
    .in_valid_i  ( ireq_valid_i ),
    .in_ready_o  ( ireq_ready_o ),
    .out_o       ( req_o        ),
    .out_valid_o ( req_valid_o  ),
    .out_ready_i ( req_ready_i  ),
    .idx_o       (              )
  );

  // Upper ID bits name the initiator
  assign dst = rsp_i.id[TID_W-1 -: IDX_W];

  always_comb
  begin
    for (int i = 0; i < NB_INIT; i++)
      irsp_valid_o[i] = rsp_valid_i && (dst == IDX_W'(i));
  end

  assign irsp_o      = rsp_i;
  assign rsp_ready_o = |(irsp_valid_o & irsp_ready_i);

  a_dst_range : assert property (@(posedge clk) disable iff (rst_i)
    rsp_valid_i |-> int'(dst) < NB_INIT);

endmodule

//--- rtl/initiator_port.sv
`timescale 1ns/1ns

module initiator_port
  import xbar_pkg::*;
#(
  parameter int NB_TARG  = 2,
  parameter int PORT_IDX = 0
)
(
  input  logic                           clk,
  input  logic                           rst_i,
  input  init_req_t                      req_i,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  output init_rsp_t                      rsp_o,
  output logic                           rsp_valid_o,
  input  logic                           rsp_ready_i,
  input  logic [NB_TARG-1:0][ADDR_W-1:0] start_addr_i,
  input  logic [NB_TARG-1:0][ADDR_W-1:0] end_addr_i,
  output targ_req_t                      treq_o,
  output logic [NB_TARG-1:0]             treq_valid_o,
  input  logic [NB_TARG-1:0]             treq_ready_i,
  input  targ_rsp_t                      trsp_i [NB_TARG-1:0],
  input  logic [NB_TARG-1:0]             trsp_valid_i,
  output logic [NB_TARG-1:0]             trsp_ready_o
);

  localparam int SRC_W = $clog2(NB_TARG + 1);

  logic [NB_TARG-1:0] sel;
  logic               miss;
  logic [OUTST_W-1:0] outst_q;
  logic [NB_TARG-1:0] last_tgt_q;
  logic               hit_ok;
  logic               miss_ok;
  logic               req_fire;
  logic               rsp_fire;
  logic               decerr_q;
  logic [ID_W-1:0]    decerr_id_q;
  targ_rsp_t          mrg_in [NB_TARG:0];
  logic [NB_TARG:0]   mrg_valid;
  logic [NB_TARG:0]   mrg_ready;
  targ_rsp_t          mrg_out;
  logic [SRC_W-1:0]   mrg_src;

  addr_decoder #(
    .NB_TARG      ( NB_TARG      )
  ) u_dec (
    .addr_i       ( req_i.addr   ),
    .start_addr_i ( start_addr_i ),
    .end_addr_i   ( end_addr_i   ),
    .sel_o        ( sel          ),
    .miss_o       ( miss         )
  );

  // Follow-up to the same target keeps order there, anything else drains first
  assign hit_ok  = ~miss & (outst_q != '1) &
                   ((outst_q == '0) | (|(sel & last_tgt_q)));
  assign miss_ok = miss & (outst_q == '0) & ~decerr_q;

  assign treq_valid_o = sel & {NB_TARG{req_valid_i & hit_ok}};
  assign treq_o.addr  = req_i.addr;
  assign treq_o.we    = req_i.we;
  assign treq_o.wdata = req_i.wdata;
  assign treq_o.strb  = req_i.strb;
  assign treq_o.id    = {IDX_W'(PORT_IDX), req_i.id};

  assign req_ready_o = (|(treq_valid_o & treq_ready_i)) | (req_valid_i & miss_ok);
  assign req_fire    = req_valid_i & req_ready_o;
  assign rsp_fire    = rsp_valid_o & rsp_ready_i;

  // Misses count as outstanding with no target remembered
  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      outst_q    <= '0;
      last_tgt_q <= '0;
      decerr_q   <= 1'b0;
    end
    else
    begin
      if (req_fire & ~rsp_fire)
        outst_q <= outst_q + 1'b1;
      else if (rsp_fire & ~req_fire)
        outst_q <= outst_q - 1'b1;
      if (req_fire)
        last_tgt_q <= sel;
      if (req_fire & miss)
        decerr_q <= 1'b1;
      else if (rsp_fire && (mrg_src == SRC_W'(NB_TARG)))
        decerr_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_fire & miss)
      decerr_id_q <= req_i.id;
  end

  for (genvar t = 0; t < NB_TARG; t++)
  begin : g_mrg
    assign mrg_in[t] = trsp_i[t];
  end

  // Local error responder sits on the last merge input
  assign mrg_in[NB_TARG] = '{rdata: '0, resp: DECERR, id: {IDX_W'(PORT_IDX), decerr_id_q}};
  assign mrg_valid       = {decerr_q, trsp_valid_i};
  assign trsp_ready_o    = mrg_ready[NB_TARG-1:0];

  rr_arb_mux #(
    .payload_t   ( targ_rsp_t  ),
    .N           ( NB_TARG + 1 )
  ) u_rsp_mux (
    .clk         ( clk         ),
    .rst_i       ( rst_i       ),
    .in_i        ( mrg_in      ),
    .in_valid_i  ( mrg_valid   ),
    .in_ready_o  ( mrg_ready   ),
    .out_o       ( mrg_out     ),
    .out_valid_o ( rsp_valid_o ),
    .out_ready_i ( rsp_ready_i ),
    .idx_o       ( mrg_src     )
  );

  assign rsp_o.rdata = mrg_out.rdata;
  assign rsp_o.resp  = mrg_out.resp;
  assign rsp_o.id    = mrg_out.id[ID_W-1:0];

  a_one_target : assert property (@(posedge clk) disable iff (rst_i)
    $onehot0(treq_valid_o));

  // A response never shows up without a request in flight
  a_no_underflow : assert property (@(posedge clk) disable iff (rst_i)
    rsp_fire && !req_fire |-> outst_q != '0);

endmodule

//--- rtl/rr_arb_mux.sv
`timescale 1ns/1ns

module rr_arb_mux
#(
  parameter type payload_t = logic,
  parameter int  N         = 2
)
(
  input  logic                                clk,
  input  logic                                rst_i,
  input  payload_t                            in_i [N-1:0],
  input  logic [N-1:0]                        in_valid_i,
  output logic [N-1:0]                        in_ready_o,
  output payload_t                            out_o,
  output logic                                out_valid_o,
  input  logic                                out_ready_i,
  output logic [((N > 1) ? $clog2(N) : 1)-1:0] idx_o
);

  localparam int IW = (N > 1) ? $clog2(N) : 1;

  logic [IW-1:0] ptr_q;
  logic [IW-1:0] lock_idx_q;
  logic          lock_q;
  logic [IW-1:0] sel;
  logic [N-1:0]  gnt;

  // Search starts one past the last winner
  always_comb
  begin
    int   c;
    logic found;
    found = 1'b0;
    sel   = ptr_q;
    for (int k = 1; k <= N; k++)
    begin
      c = (int'(ptr_q) + k) % N;
      if (!found && in_valid_i[c])
      begin
        sel   = IW'(c);
        found = 1'b1;
      end
    end
    // Stalled transfer keeps its grant
    if (lock_q)
      sel = lock_idx_q;
  end

  assign gnt         = N'(1) << sel;
  assign out_valid_o = |(gnt & in_valid_i);
  assign out_o       = in_i[sel];
  assign in_ready_o  = gnt & in_valid_i & {N{out_ready_i}};
  assign idx_o       = sel;

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      ptr_q      <= IW'(N - 1);
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end
    else
    begin
      lock_q <= out_valid_o & ~out_ready_i;
      if (out_valid_o)
        lock_idx_q <= sel;
      if (out_valid_o & out_ready_i)
        ptr_q <= sel;
    end
  end

  a_grant_on_valid : assert property (@(posedge clk) disable iff (rst_i)
    |in_valid_i |-> $onehot(gnt & in_valid_i));

  a_out_stable : assert property (@(posedge clk) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o));

endmodule

//--- rtl/addr_decoder.sv
`timescale 1ns/1ns

module addr_decoder
  import xbar_pkg::*;
#(
  parameter int NB_TARG = 2
)
(
  input  logic [ADDR_W-1:0]              addr_i,
  input  logic [NB_TARG-1:0][ADDR_W-1:0] start_addr_i,
  input  logic [NB_TARG-1:0][ADDR_W-1:0] end_addr_i,
  output logic [NB_TARG-1:0]             sel_o,
  output logic                           miss_o
);

  // Walk down so the lowest matching target is the last one written
  always_comb
  begin
    sel_o = '0;
    for (int t = NB_TARG - 1; t >= 0; t--)
    begin
      if ((addr_i >= start_addr_i[t]) && (addr_i <= end_addr_i[t]))
      begin
        sel_o    = '0;
        sel_o[t] = 1'b1;
      end
    end
  end

  assign miss_o = ~|sel_o;

endmodule

//--- rtl/xbar_pkg.sv
package xbar_pkg;

  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int STRB_W  = DATA_W / 8;
  localparam int ID_W    = 4;
  // Initiator index added on the target side, room for 4 initiators
  localparam int IDX_W   = 2;
  localparam int TID_W   = ID_W + IDX_W;
  localparam int OUTST_W = 4;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
    logic [ID_W-1:0]   id;
  } init_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
    logic [TID_W-1:0]  id;
  } targ_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    resp_e             resp;
    logic [ID_W-1:0]   id;
  } init_rsp_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    resp_e             resp;
    logic [TID_W-1:0]  id;
  } targ_rsp_t;

endpackage
